//--- sim/armCtrl_testdata.txt
// One line per clock cycle, all fields hex, x is a don't care
// Inputs:  InstrD ALUFlagsE(NZCV) ALUResultE[7:0] StallE FlushE
// ALU columns belong to the instruction that sits in execute at that rising edge
// Expect:  RegSrcD ImmSrcD ALUControlE BranchTakenE MemWriteM RegWriteM MemtoRegM
//          ByteMaskM RegWriteW MemtoRegW PCSrcW LoadByteW FlagsW
// ADDS, ANDS, then CMP with ADDEQ/BEQ/BNE behind it, MOVNV
E2921001 0 00 0 0 0 0 4 0 0 0 0 0 x x x x 0
E21130FF 3 00 0 0 0 0 0 0 0 1 0 0 0 0 0 0 0
EF000000 C 00 0 0 0 0 0 0 0 1 0 0 1 0 0 0 0
EF000000 0 00 0 0 0 0 0 0 0 0 0 0 1 0 0 0 3
E3510005 0 00 0 0 0 0 A 0 0 0 0 0 0 0 0 0 F
02844001 6 00 0 0 0 0 4 0 0 0 0 0 0 0 0 0 F
0A000002 0 00 0 0 1 2 4 1 0 1 0 0 0 0 0 0 F
1A000002 0 00 0 0 1 2 4 0 0 0 0 0 1 0 0 0 6
F3A05001 0 00 0 0 0 0 D 0 0 0 0 0 0 0 1 0 6
// STR word, STRB lane 2, LDRB, MOV to PC, B
E5032004 0 00 0 0 2 1 2 0 0 0 0 0 0 0 0 0 6
E5C32002 0 01 0 0 2 1 4 0 1 0 0 F 0 0 0 0 6
E5D36002 0 02 0 0 0 1 4 0 1 0 0 4 0 0 0 0 6
E3A0F008 0 02 0 0 0 0 D 0 0 1 1 4 0 0 0 0 6
EA000004 0 00 0 0 1 2 4 1 0 0 0 0 1 1 0 1 6
// ADD, stalled STR, then a flushed ADDS and drain
E2877001 0 00 0 0 0 0 4 0 0 0 0 0 0 0 1 0 6
E5032004 0 00 1 0 2 1 4 0 0 0 0 0 0 0 1 0 6
E5032004 0 00 0 0 2 1 2 0 0 1 0 0 0 0 1 0 6
E2921001 0 00 0 1 0 0 0 0 1 0 0 F 1 0 0 0 6
EF000000 F 00 0 0 0 0 0 0 0 0 0 0 0 0 0 0 6
EF000000 0 00 0 0 0 0 0 0 0 0 0 0 0 0 0 0 6
EF000000 0 00 0 0 0 0 0 0 0 0 0 0 0 0 0 0 6
EF000000 0 00 0 0 0 0 0 0 0 0 0 0 0 0 0 0 6

//--- tb.f
+incdir+sim
source/armIsaPkg.sv
source/armCtrlPkg.sv
source/stageBus.sv
source/decodeStage.sv
source/executeStage.sv
source/retireStage.sv
source/armController.sv
sim/tbArmController.sv

//--- sim/tbCheck.svh
`ifndef TB_CHECK_SVH
`define TB_CHECK_SVH

// Compare one DUT output with its expected value
// An expected value with x in it is a don't care during pipeline fill
task automatic compareValue(
  input string       testName,
  input logic [31:0] expected,
  input logic [31:0] actual
);
  if (!$isunknown(expected) && (expected !== actual)) begin
    $display("** Error %s: expected %h, actual %h", testName, expected, actual);
    $display("Test failures found");
    $fatal(1, "Stopping at the first mismatch");
  end
endtask

`endif

//--- sim/tbArmController.sv
`timescale 1ns/1ps

module tbArmController;

  localparam int CLK_PERIOD  = 100;
  localparam int MAX_VECTORS = 64;
  localparam int FILL_CYCLES = 20;  // Reset plus pipeline drain slack
  localparam logic [31:0] BUBBLE_INSTR = 32'hEF000000;  // SWI space decodes as a bubble

  // DUT inputs
  logic        clk;
  logic        rstN;
  logic [31:0] InstrD;
  logic        StallE;
  logic        FlushE;
  logic [3:0]  ALUFlagsE;
  logic [31:0] ALUResultE;

  // DUT outputs
  logic [1:0]  RegSrcD;
  logic [1:0]  ImmSrcD;
  logic [3:0]  ALUControlE;
  logic        ALUSrcE;
  logic        BranchTakenE;
  logic        MemWriteM;
  logic        RegWriteM;
  logic        MemtoRegM;
  logic [3:0]  ByteMaskM;
  logic        RegWriteW;
  logic        MemtoRegW;
  logic        PCSrcW;
  logic        LoadByteW;
  logic [3:0]  FlagsW;

  // ==========================================================================
  // Vector storage with one entry per data line
  // ==========================================================================
  logic [31:0] instrVec    [MAX_VECTORS];
  logic [3:0]  aluFlagsVec [MAX_VECTORS];
  logic [7:0]  resultLoVec [MAX_VECTORS];  // Low byte of ALUResultE
  logic        stallVec    [MAX_VECTORS];
  logic        flushVec    [MAX_VECTORS];
  logic [23:0] expectVec   [MAX_VECTORS];  // Packed expected outputs

  int numVectors = 0;
  int cycleCount = 0;
  int cycleLimit = MAX_VECTORS + FILL_CYCLES;

  logic [31:0] instrE;  // Instruction held in the execute stage

  `include "tbCheck.svh"

  armController i_armController (
    .clk, .rstN, .InstrD, .StallE, .FlushE, .ALUFlagsE, .ALUResultE,
    .RegSrcD, .ImmSrcD, .ALUControlE, .ALUSrcE, .BranchTakenE,
    .MemWriteM, .RegWriteM, .MemtoRegM, .ByteMaskM,
    .RegWriteW, .MemtoRegW, .PCSrcW, .LoadByteW, .FlagsW
  );

  always #(CLK_PERIOD/2) clk = ~clk;

  // Run limit from the number of vectors
  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= cycleLimit) begin
      $display("Test failures found");
      $fatal(1, "Timeout, the run did not end within %0d clock cycles", cycleLimit);
    end
  end

  // Execute stage holds on a stall and takes a bubble on a flush
  always @(posedge clk or negedge rstN) begin
    if (!rstN)
      instrE <= BUBBLE_INSTR;
    else if (!StallE)
      instrE <= FlushE ? BUBBLE_INSTR : InstrD;
  end

  // Operand B is the immediate for DP with I set, for loads and stores with I clear
  // and for branches
  function automatic logic aluSrcFor(input logic [31:0] instr);
    case (instr[27:26])
      2'b00:   return instr[25];
      2'b01:   return ~instr[25];
      2'b10:   return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  // ==========================================================================
  // Data file reader
  // ==========================================================================
  task automatic readVectors();
    int          fd;
    int          fields;
    string       lineText;
    logic [31:0] instr;
    logic [3:0]  aluFlags;
    logic [7:0]  resultLo;
    logic        stall;
    logic        flush;
    logic [1:0]  regSrc;
    logic [1:0]  immSrc;
    logic [3:0]  aluCtl;
    logic        brTaken;
    logic        memWM;
    logic        regWM;
    logic        memtoRegM;
    logic [3:0]  maskM;
    logic        regWW;
    logic        memtoRegW;
    logic        pcSrcW;
    logic        loadByteW;
    logic [3:0]  flags;
    fd = $fopen("sim/armCtrl_testdata.txt", "r");
    if (fd == 0) begin
      $display("Test failures found");
      $fatal(1, "Could not open the vector file sim/armCtrl_testdata.txt");
    end else begin
      while (!$feof(fd)) begin
        fields = 0;
        if ($fgets(lineText, fd) != 0)
          fields = $sscanf(lineText,
                           "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                           instr, aluFlags, resultLo, stall, flush,
                           regSrc, immSrc, aluCtl, brTaken,
                           memWM, regWM, memtoRegM, maskM,
                           regWW, memtoRegW, pcSrcW, loadByteW, flags);
        if (fields == 18 && numVectors < MAX_VECTORS) begin  // Comment lines give 0
          instrVec[numVectors]    = instr;
          aluFlagsVec[numVectors] = aluFlags;
          resultLoVec[numVectors] = resultLo;
          stallVec[numVectors]    = stall;
          flushVec[numVectors]    = flush;
          expectVec[numVectors]   = {regSrc, immSrc, aluCtl, brTaken,
                                     memWM, regWM, memtoRegM, maskM,
                                     regWW, memtoRegW, pcSrcW, loadByteW, flags};
          numVectors++;
        end
      end
      $fclose(fd);
      cycleLimit = numVectors + FILL_CYCLES;
    end
  endtask

  // Inputs for one cycle on the falling edge
  task automatic applyVector(input int idx);
    InstrD     = instrVec[idx];
    ALUFlagsE  = aluFlagsVec[idx];
    ALUResultE = {24'h0, resultLoVec[idx]};
    StallE     = stallVec[idx];
    FlushE     = flushVec[idx];
  endtask

  // Outputs after the rising edge of that cycle
  task automatic checkOutputs(input int idx);
    logic [23:0] e;
    string       tag;
    e   = expectVec[idx];
    tag = $sformatf("vector %0d", idx);
    compareValue({tag, " RegSrcD"},      e[23:22], RegSrcD);
    compareValue({tag, " ImmSrcD"},      e[21:20], ImmSrcD);
    compareValue({tag, " ALUControlE"},  e[19:16], ALUControlE);
    compareValue({tag, " ALUSrcE"},      aluSrcFor(instrE), ALUSrcE);
    compareValue({tag, " BranchTakenE"}, e[15],    BranchTakenE);
    compareValue({tag, " MemWriteM"},    e[14],    MemWriteM);
    compareValue({tag, " RegWriteM"},    e[13],    RegWriteM);
    compareValue({tag, " MemtoRegM"},    e[12],    MemtoRegM);
    compareValue({tag, " ByteMaskM"},    e[11:8],  ByteMaskM);
    compareValue({tag, " RegWriteW"},    e[7],     RegWriteW);
    compareValue({tag, " MemtoRegW"},    e[6],     MemtoRegW);
    compareValue({tag, " PCSrcW"},       e[5],     PCSrcW);
    compareValue({tag, " LoadByteW"},    e[4],     LoadByteW);
    compareValue({tag, " FlagsW"},       e[3:0],   FlagsW);
  endtask

  // ==========================================================================
  // Main sequence
  // ==========================================================================
  initial begin
    clk        = 1'b0;
    rstN       = 1'b0;
    InstrD     = BUBBLE_INSTR;
    StallE     = 1'b0;
    FlushE     = 1'b0;
    ALUFlagsE  = 4'h0;
    ALUResultE = 32'h0;
    readVectors();
    repeat (2) @(negedge clk);  // Two rising edges in reset
    rstN = 1'b1;
    for (int k = 0; k < numVectors; k++) begin
      if (k > 0) begin
        @(negedge clk);
        checkOutputs(k - 1);  // Sampled before the new drive
      end
      applyVector(k);
    end
    @(negedge clk);
    checkOutputs(numVectors - 1);
    $display("All tests passed!");
    $finish;
  end

endmodule

//--- source/armController.sv
`timescale 1ns/1ps

module armController (
  input  logic        clk,
  input  logic        rstN,
  // Decode
  input  logic [31:0] InstrD,
  output logic [1:0]  RegSrcD,
  output logic [1:0]  ImmSrcD,
  // Hazard control
  input  logic        StallE,
  input  logic        FlushE,
  // Execute, ALU side
  input  logic [3:0]  ALUFlagsE,
  input  logic [31:0] ALUResultE,
  output logic [3:0]  ALUControlE,
  output logic        ALUSrcE,
  output logic        BranchTakenE,
  // Memory
  output logic        MemWriteM,
  output logic        RegWriteM,
  output logic        MemtoRegM,
  output logic [3:0]  ByteMaskM,
  // Writeback
  output logic        RegWriteW,
  output logic        MemtoRegW,
  output logic        PCSrcW,
  output logic        LoadByteW,
  output logic [3:0]  FlagsW
);

  execBus   exBus ();  // Decode to execute
  retireBus rtBus ();  // Execute to memory/writeback

  decodeStage i_decode (
    .clk, .rstN, .InstrD, .StallE, .FlushE,
    .RegSrcD, .ImmSrcD,
    .ex (exBus.producer)
  );

  executeStage i_execute (
    .clk, .rstN, .StallE, .ALUFlagsE, .ALUResultE,
    .ALUControlE, .ALUSrcE, .BranchTakenE,
    .ex (exBus.consumer),
    .rt (rtBus.producer)
  );

  retireStage i_retire (
    .clk, .rstN, .StallE,
    .rt (rtBus.consumer),
    .MemWriteM, .RegWriteM, .MemtoRegM, .ByteMaskM,
    .RegWriteW, .MemtoRegW, .PCSrcW, .LoadByteW, .FlagsW
  );

endmodule

//--- source/retireStage.sv
`timescale 1ns/1ps

module retireStage (
  input  logic       clk,
  input  logic       rstN,
  input  logic       StallE,
  retireBus.consumer rt,
  output logic       MemWriteM,
  output logic       RegWriteM,
  output logic       MemtoRegM,
  output logic [3:0] ByteMaskM,
  output logic       RegWriteW,
  output logic       MemtoRegW,
  output logic       PCSrcW,
  output logic       LoadByteW,
  output logic [3:0] FlagsW
);

  logic              setFlagsW;
  armCtrlPkg::flagsT flagsNextW;
  armCtrlPkg::flagsT flagsQ;     // NZCV status register

  // Memory stage, straight from the execute register
  assign MemWriteM = rt.memWrite;
  assign RegWriteM = rt.regWrite;
  assign MemtoRegM = rt.memtoReg;
  assign ByteMaskM = rt.byteMask;

  // ==========================================================================
  // Memory to writeback register
  // ==========================================================================
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      RegWriteW <= 1'b0;
      MemtoRegW <= 1'b0;
      PCSrcW    <= 1'b0;
      LoadByteW <= 1'b0;
      setFlagsW <= 1'b0;
    end else if (!StallE) begin
      RegWriteW <= rt.regWrite;
      MemtoRegW <= rt.memtoReg;
      PCSrcW    <= rt.pcSrc;
      LoadByteW <= rt.loadByte;
      setFlagsW <= rt.setFlags;
    end
  end

  always_ff @(posedge clk) begin
    if (!StallE)
      flagsNextW <= rt.flagsNext;
  end

  // Status flags, updated as writeback completes
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN)
      flagsQ <= '0;
    else if (!StallE && setFlagsW)
      flagsQ <= flagsNextW;
  end

  assign FlagsW = flagsQ;

  // Newest flags win: memory, then writeback, then the register
  assign rt.flagsFwd = rt.setFlags ? rt.flagsNext :
                       setFlagsW   ? flagsNextW   : flagsQ;

endmodule

//--- source/executeStage.sv
`timescale 1ns/1ps

module executeStage (
  input  logic        clk,
  input  logic        rstN,
  input  logic        StallE,
  input  logic [3:0]  ALUFlagsE,
  input  logic [31:0] ALUResultE,
  output logic [3:0]  ALUControlE,
  output logic        ALUSrcE,
  output logic        BranchTakenE,
  execBus.consumer    ex,
  retireBus.producer  rt
);

  armCtrlPkg::flagsT    flagsE;      // Forwarded flags used by the condition
  armCtrlPkg::flagsT    aluFlags;
  armCtrlPkg::flagsT    flagsNextE;
  armCtrlPkg::byteMaskT byteMaskE;
  logic                 condExE;
  logic                 regWriteE;
  logic                 memWriteE;
  logic                 pcSrcE;
  logic                 setFlagsE;

  assign ALUControlE = ex.ctrl.aluControl;
  assign ALUSrcE     = ex.ctrl.aluSrc;

  assign flagsE   = rt.flagsFwd;
  assign aluFlags = ALUFlagsE;

  // ==========================================================================
  // Condition check
  // ==========================================================================
  always_comb begin
    unique case (ex.ctrl.cond)
      armIsaPkg::EQ: condExE = flagsE.z;
      armIsaPkg::NE: condExE = ~flagsE.z;
      armIsaPkg::CS: condExE = flagsE.c;
      armIsaPkg::CC: condExE = ~flagsE.c;
      armIsaPkg::MI: condExE = flagsE.n;
      armIsaPkg::PL: condExE = ~flagsE.n;
      armIsaPkg::VS: condExE = flagsE.v;
      armIsaPkg::VC: condExE = ~flagsE.v;
      armIsaPkg::HI: condExE = flagsE.c & ~flagsE.z;   // Unsigned higher
      armIsaPkg::LS: condExE = ~flagsE.c | flagsE.z;
      armIsaPkg::GE: condExE = (flagsE.n == flagsE.v);  // Signed compares
      armIsaPkg::LT: condExE = (flagsE.n != flagsE.v);
      armIsaPkg::GT: condExE = ~flagsE.z & (flagsE.n == flagsE.v);
      armIsaPkg::LE: condExE = flagsE.z | (flagsE.n != flagsE.v);
      armIsaPkg::AL: condExE = 1'b1;
      default:       condExE = 1'b0;  // NV
    endcase
  end

  // Controls killed by a failed condition
  assign BranchTakenE = ex.ctrl.branch & condExE;
  // R15 writes leave the register file alone and go out through pcSrc
  assign regWriteE    = ex.ctrl.regWrite & ~ex.rdIsPc & condExE;
  assign memWriteE    = ex.ctrl.memWrite & condExE;
  assign pcSrcE       = ex.ctrl.pcSrc & condExE;
  assign setFlagsE    = (|ex.ctrl.flagWrite) & condExE;

  // Each flag pair chosen by its own write enable
  assign {flagsNextE.n, flagsNextE.z} = ex.ctrl.flagWrite[armCtrlPkg::FW_NZ] ?
                                        {aluFlags.n, aluFlags.z} : {flagsE.n, flagsE.z};
  assign {flagsNextE.c, flagsNextE.v} = ex.ctrl.flagWrite[armCtrlPkg::FW_CV] ?
                                        {aluFlags.c, aluFlags.v} : {flagsE.c, flagsE.v};

  // Byte lanes from the low address bits
  always_comb begin
    byteMaskE = '0;
    if (ex.instrClass == armIsaPkg::LOADSTORE) begin
      if (ex.ctrl.byteAccess)
        byteMaskE[ALUResultE[1:0]] = 1'b1;  // One-hot lane
      else
        byteMaskE = '1;                     // Full word
    end
  end

  // ==========================================================================
  // Execute to memory register
  // ==========================================================================
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      rt.regWrite <= 1'b0;
      rt.memWrite <= 1'b0;
      rt.memtoReg <= 1'b0;
      rt.pcSrc    <= 1'b0;
      rt.setFlags <= 1'b0;
      rt.byteMask <= '0;
      rt.loadByte <= 1'b0;
    end else if (!StallE) begin
      rt.regWrite <= regWriteE;
      rt.memWrite <= memWriteE;
      rt.memtoReg <= ex.ctrl.memtoReg;
      rt.pcSrc    <= pcSrcE;
      rt.setFlags <= setFlagsE;
      rt.byteMask <= byteMaskE;
      rt.loadByte <= ex.ctrl.loadByte;
    end
  end

  // Flags carried into memory with the instruction
  always_ff @(posedge clk) begin
    if (!StallE)
      rt.flagsNext <= flagsNextE;
  end

endmodule

//--- source/decodeStage.sv
`timescale 1ns/1ps

module decodeStage (
  input  logic        clk,
  input  logic        rstN,
  input  logic [31:0] InstrD,
  input  logic        StallE,
  input  logic        FlushE,
  output logic [1:0]  RegSrcD,
  output logic [1:0]  ImmSrcD,
  execBus.producer    ex
);

  armIsaPkg::instrClassT instrClassD;
  armIsaPkg::dpOpT       opD;
  armCtrlPkg::ctrlWordT  ctrlD;
  logic                  rdIsPcD;
  logic                  iBit;
  logic                  sBit;
  logic                  lBit;
  logic                  bBit;
  logic                  uBit;
  logic                  testOp;    // TST/TEQ/CMP/CMN
  logic                  arithOp;   // Opcode produces C and V
  logic                  dpUnused;  // Misc/MUL/RSR space inside class 00

  // ==========================================================================
  // Field extraction
  // ==========================================================================
  assign opD  = armIsaPkg::dpOpT'(InstrD[armIsaPkg::OPCODE_MSB -: 4]);
  assign iBit = InstrD[armIsaPkg::IMM_BIT];
  assign sBit = InstrD[armIsaPkg::SBIT];
  assign lBit = InstrD[armIsaPkg::LBIT];
  assign bBit = InstrD[armIsaPkg::BBIT];
  assign uBit = InstrD[armIsaPkg::UBIT];

  assign testOp  = (InstrD[armIsaPkg::OPCODE_MSB -: 2] == 2'b10);
  assign arithOp = opD inside {armIsaPkg::SUB, armIsaPkg::RSB, armIsaPkg::ADD,
                               armIsaPkg::ADC, armIsaPkg::SBC, armIsaPkg::RSC,
                               armIsaPkg::CMP, armIsaPkg::CMN};

  // Bit 4 with a register operand is RSR, multiply or halfword space.
  // Compare opcodes without S hold MSR/MRS, BX and CLZ
  assign dpUnused = (~iBit & InstrD[armIsaPkg::RSR_BIT]) | (testOp & ~sBit);

  always_comb begin
    unique case (InstrD[armIsaPkg::CLASS_MSB -: 2])
      2'b00:   instrClassD = dpUnused ? armIsaPkg::NONE : armIsaPkg::DATAPROC;
      2'b01:   instrClassD = (iBit & InstrD[armIsaPkg::RSR_BIT]) ? armIsaPkg::NONE
                                                                  : armIsaPkg::LOADSTORE;
      2'b10:   instrClassD = InstrD[armIsaPkg::LINK_BIT] ? armIsaPkg::NONE  // BL not kept
                                                          : armIsaPkg::BRANCH;
      default: instrClassD = armIsaPkg::NONE;  // SWI, coprocessor
    endcase
  end

  // ==========================================================================
  // Control word
  // ==========================================================================
  always_comb begin
    ctrlD      = armCtrlPkg::BUBBLE_CTRL;
    ctrlD.cond = armIsaPkg::condT'(InstrD[armIsaPkg::COND_MSB -: 4]);
    case (instrClassD)
      armIsaPkg::DATAPROC: begin
        ctrlD.aluControl = opD;
        ctrlD.aluSrc     = iBit;
        ctrlD.regWrite   = ~testOp;
        ctrlD.flagWrite[armCtrlPkg::FW_NZ] = sBit;
        ctrlD.flagWrite[armCtrlPkg::FW_CV] = sBit & arithOp;  // Logical ops keep C, V
      end
      armIsaPkg::LOADSTORE: begin
        ctrlD.aluControl = uBit ? armIsaPkg::ADD : armIsaPkg::SUB;
        ctrlD.aluSrc     = ~iBit;  // I clear means 12-bit immediate offset
        ctrlD.regWrite   = lBit;
        ctrlD.memtoReg   = lBit;
        ctrlD.memWrite   = ~lBit;
        ctrlD.byteAccess = bBit;
        ctrlD.loadByte   = lBit & bBit;
      end
      armIsaPkg::BRANCH: begin
        ctrlD.aluControl = armIsaPkg::ADD;  // PC + offset
        ctrlD.aluSrc     = 1'b1;
        ctrlD.branch     = 1'b1;
        ctrlD.pcSrc      = 1'b1;
      end
      default: ;  // Stays a bubble, condition field is harmless
    endcase
    // Any register write aimed at R15 redirects the PC
    rdIsPcD     = ctrlD.regWrite & (InstrD[armIsaPkg::RD_MSB -: 4] == armIsaPkg::PC_REG);
    ctrlD.pcSrc = ctrlD.pcSrc | rdIsPcD;
  end

  // Datapath selects, valid in the decode cycle
  assign RegSrcD[1] = (instrClassD == armIsaPkg::LOADSTORE) & ~lBit;  // Store reads Rd
  assign RegSrcD[0] = (instrClassD == armIsaPkg::BRANCH);             // Branch reads PC

  always_comb begin
    case (instrClassD)
      armIsaPkg::LOADSTORE: ImmSrcD = 2'b01;  // 12-bit offset
      armIsaPkg::BRANCH:    ImmSrcD = 2'b10;  // 24-bit word offset
      default:              ImmSrcD = 2'b00;  // Rotated 8-bit immediate
    endcase
  end

  // ==========================================================================
  // Decode to execute register
  // ==========================================================================
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      ex.ctrl       <= armCtrlPkg::BUBBLE_CTRL;
      ex.rdIsPc     <= 1'b0;
      ex.instrClass <= armIsaPkg::NONE;
    end else if (!StallE) begin
      if (FlushE) begin  // Insert a bubble
        ex.ctrl       <= armCtrlPkg::BUBBLE_CTRL;
        ex.rdIsPc     <= 1'b0;
        ex.instrClass <= armIsaPkg::NONE;
      end else begin
        ex.ctrl       <= ctrlD;
        ex.rdIsPc     <= rdIsPcD;
        ex.instrClass <= instrClassD;
      end
    end
  end

endmodule

//--- source/stageBus.sv
`timescale 1ns/1ps

// ==========================================================================
// Decode to execute
// ==========================================================================
interface execBus;
  armCtrlPkg::ctrlWordT  ctrl;       // Registered control word
  logic                  rdIsPc;     // Instruction writes R15
  armIsaPkg::instrClassT instrClass;

  modport producer (output ctrl, rdIsPc, instrClass);
  modport consumer (input ctrl, rdIsPc, instrClass);
endinterface

// ==========================================================================
// Execute to memory/writeback, flags come back the other way
// ==========================================================================
interface retireBus;
  // Memory-stage controls, already condition gated
  logic                 regWrite;
  logic                 memWrite;
  logic                 memtoReg;
  logic                 pcSrc;
  logic                 setFlags;
  armCtrlPkg::flagsT    flagsNext;  // Flags this instruction leaves behind
  armCtrlPkg::byteMaskT byteMask;
  logic                 loadByte;
  armCtrlPkg::flagsT    flagsFwd;   // Newest flags for the condition check

  modport producer (
    output regWrite, memWrite, memtoReg, pcSrc,
    output setFlags, flagsNext, byteMask, loadByte,
    input  flagsFwd
  );

  modport consumer (
    input  regWrite, memWrite, memtoReg, pcSrc,
    input  setFlags, flagsNext, byteMask, loadByte,
    output flagsFwd
  );
endinterface

//--- source/armCtrlPkg.sv
package armCtrlPkg;

  localparam int BYTE_LANES = 4;

  // flagWrite bit assignment
  localparam int FW_NZ = 1;
  localparam int FW_CV = 0;

  // Status flags, same order as CPSR[31:28]
  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic v;
  } flagsT;

  typedef logic [BYTE_LANES-1:0] byteMaskT; // One bit per byte lane

  // Decoded controls carried from decode into execute
  typedef struct packed {
    armIsaPkg::dpOpT aluControl;
    logic            aluSrc;     // Immediate/offset as ALU operand B
    logic [1:0]      flagWrite;  // {NZ, CV}
    logic            branch;
    logic            memWrite;
    logic            regWrite;
    logic            memtoReg;
    logic            pcSrc;      // Result goes to the PC
    logic            byteAccess;
    logic            loadByte;
    armIsaPkg::condT cond;
  } ctrlWordT;

  // Nothing enabled, used for flush and undecoded encodings
  localparam ctrlWordT BUBBLE_CTRL = '{
    aluControl: armIsaPkg::AND, aluSrc: 1'b0, flagWrite: 2'b00,
    branch: 1'b0, memWrite: 1'b0, regWrite: 1'b0, memtoReg: 1'b0,
    pcSrc: 1'b0, byteAccess: 1'b0, loadByte: 1'b0, cond: armIsaPkg::EQ
  };

endpackage

//--- source/armIsaPkg.sv
package armIsaPkg;

  // Bit positions inside a 32-bit ARM instruction word
  localparam int COND_MSB   = 31; // Condition field 31:28
  localparam int CLASS_MSB  = 27; // Class field 27:26
  localparam int IMM_BIT    = 25; // I bit, immediate operand form
  localparam int OPCODE_MSB = 24; // DP opcode 24:21
  localparam int LINK_BIT   = 24; // Branch with link when set
  localparam int UBIT       = 23; // Offset added when set
  localparam int BBIT       = 22; // Byte access when set
  localparam int SBIT       = 20; // DP flag update
  localparam int LBIT       = 20; // Load when set, same bit as S
  localparam int RD_MSB     = 15; // Destination register 15:12
  localparam int RSR_BIT    = 4;  // Register-shifted register, also MUL/halfword space

  localparam logic [3:0] PC_REG = 4'd15;

  // Condition codes, encoding order of the cond field
  typedef enum logic [3:0] {
    EQ, NE, CS, CC,
    MI, PL, VS, VC,
    HI, LS, GE, LT,
    GT, LE, AL, NV   // NV never executes here
  } condT;

  // Data-processing opcodes, bits 24:21
  typedef enum logic [3:0] {
    AND, EOR, SUB, RSB,
    ADD, ADC, SBC, RSC,
    TST, TEQ, CMP, CMN,  // Compare group, no register write
    ORR, MOV, BIC, MVN
  } dpOpT;

  // Decoded class, NONE covers everything that is not implemented
  typedef enum logic [1:0] {
    DATAPROC,
    LOADSTORE,
    BRANCH,
    NONE
  } instrClassT;

endpackage
